// ==== i2c_bridge_pkg.sv ====
package i2c_bridge_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [6:0]  dev_addr_t;
	typedef logic [3:0]  axil_addr_t;
	typedef logic [1:0]  axil_resp_t;
	typedef logic [2:0]  fifo_level_t;

	typedef enum logic [2:0] {IDLE, ADDR, DWR, DRD, ACKO, AACKO, ACKI} phy_state_t;

	// ----------------------------------------------------------------------
	// bit timing, in clk cycles
	// ----------------------------------------------------------------------
	localparam int GLITCH_LEN = 4;
	localparam int NEG_DLY    = 8;
	localparam int POS_DLY    = 4;
	localparam int RD_DLY     = 6;

	localparam int        FIFO_DEPTH   = 4;
	localparam dev_addr_t GENERAL_CALL = 7'h00;

	// register map
	localparam axil_addr_t REG_CTRL   = 4'h0;
	localparam axil_addr_t REG_STATUS = 4'h4;
	localparam axil_addr_t REG_RXDATA = 4'h8;
	localparam axil_addr_t REG_TXDATA = 4'hC;

	localparam axil_resp_t RESP_OKAY   = 2'd0;
	localparam axil_resp_t RESP_SLVERR = 2'd2;

	// status bits
	localparam int ST_RX_EMPTY = 0;
	localparam int ST_RX_FULL  = 1;
	localparam int ST_TX_EMPTY = 2;
	localparam int ST_TX_FULL  = 3;
	localparam int ST_WDONE    = 4;
	localparam int ST_RDONE    = 5;
	localparam int ST_RERR     = 6;

endpackage

// ==== i2c_event_if.sv ====
interface i2c_event_if;

	// one-cycle pulses from the bus side
	logic wdone;
	logic rdone;
	logic rerr;

	// address of the last acknowledged transfer
	i2c_bridge_pkg::dev_addr_t dev_addr;

	modport phy (
		output wdone, rdone, rerr, dev_addr
	);

	modport regs (
		input wdone, rdone, rerr, dev_addr
	);

endinterface

// ==== i2c_pin_filter.sv ====
module i2c_pin_filter (
	input  logic clk,
	input  logic rst,
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_o,
	output logic sda_o,
	output logic scl_rise_o,
	output logic scl_fall_o,
	output logic start_o,
	output logic stop_o
);

	logic [i2c_bridge_pkg::GLITCH_LEN-1:0] scl_sh;
	logic [i2c_bridge_pkg::GLITCH_LEN-1:0] sda_sh;
	logic scl_d;
	logic sda_d;

	// level only moves once the older samples all agree
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_sh <= '1;
			sda_sh <= '1;
			scl_o  <= 1'b1;
			sda_o  <= 1'b1;
		end else begin
			scl_sh <= {scl_sh[i2c_bridge_pkg::GLITCH_LEN-2:0], scl_i};
			sda_sh <= {sda_sh[i2c_bridge_pkg::GLITCH_LEN-2:0], sda_i};
			if (&scl_sh[i2c_bridge_pkg::GLITCH_LEN-1:1])
				scl_o <= 1'b1;
			else if (!(|scl_sh[i2c_bridge_pkg::GLITCH_LEN-1:1]))
				scl_o <= 1'b0;
			if (&sda_sh[i2c_bridge_pkg::GLITCH_LEN-1:1])
				sda_o <= 1'b1;
			else if (!(|sda_sh[i2c_bridge_pkg::GLITCH_LEN-1:1]))
				sda_o <= 1'b0;
		end
	end

	// edges and bus conditions follow the level by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_d      <= 1'b1;
			sda_d      <= 1'b1;
			scl_rise_o <= 1'b0;
			scl_fall_o <= 1'b0;
			start_o    <= 1'b0;
			stop_o     <= 1'b0;
		end else begin
			scl_d      <= scl_o;
			sda_d      <= sda_o;
			scl_rise_o <= scl_o && !scl_d;
			scl_fall_o <= !scl_o && scl_d;
			// sda falls or rises while scl stays high
			start_o    <= scl_o && scl_d && sda_d && !sda_o;
			stop_o     <= scl_o && scl_d && !sda_d && sda_o;
		end
	end

	// a filtered level holds for at least three cycles once it moves
	assert property (@(posedge clk) disable iff (rst)
		scl_o != $past(scl_o) |->
		$past(scl_o) == $past(scl_o, 2) && $past(scl_o, 2) == $past(scl_o, 3))
		else $error("filtered scl moved inside the glitch window");

	assert property (@(posedge clk) disable iff (rst)
		sda_o != $past(sda_o) |->
		$past(sda_o) == $past(sda_o, 2) && $past(sda_o, 2) == $past(sda_o, 3))
		else $error("filtered sda moved inside the glitch window");

endmodule

// ==== i2c_target_phy.sv ====
module i2c_target_phy (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      scl,
	input  logic                      sda,
	input  logic                      scl_rise,
	input  logic                      scl_fall,
	input  logic                      start,
	input  logic                      stop,
	input  i2c_bridge_pkg::dev_addr_t own_addr_i,
	input  logic                      rx_full_i,
	input  logic                      tx_empty_i,
	input  i2c_bridge_pkg::word_t     tx_word_i,
	output logic                      rx_push_o,
	output i2c_bridge_pkg::word_t     rx_word_o,
	output logic                      tx_pop_o,
	output logic                      sda_oe_o,
	i2c_event_if.phy                  ev
);

	i2c_bridge_pkg::phy_state_t state;
	i2c_bridge_pkg::phy_state_t state_n;
	i2c_bridge_pkg::word_t      sbuf;
	i2c_bridge_pkg::byte_t      addr_byte;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [3:0] neg_cnt;
	logic [3:0] pos_cnt;
	logic       start_seen;
	logic       ack_q;
	logic       rw;
	logic       acki;
	logic       neg_dly;
	logic       sample;
	logic       byte_end;
	logic       addr_ok;
	logic       rd_err;

	// ----------------------------------------------------------------------
	// delays after scl edges
	// ----------------------------------------------------------------------
	assign neg_dly = neg_cnt == 4'(i2c_bridge_pkg::NEG_DLY);
	// only sample while scl is still high
	assign sample  = pos_cnt == 4'(i2c_bridge_pkg::POS_DLY) && scl;

	always_ff @(posedge clk) begin
		if (rst)
			neg_cnt <= '0;
		else if (scl_fall)
			neg_cnt <= 4'd1;
		else if (neg_cnt != '0 && !neg_dly)
			neg_cnt <= neg_cnt + 4'd1;
		else
			neg_cnt <= '0;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pos_cnt <= '0;
		else if (scl_rise)
			pos_cnt <= 4'd1;
		else if (pos_cnt != '0 && pos_cnt != 4'(i2c_bridge_pkg::POS_DLY))
			pos_cnt <= pos_cnt + 4'd1;
		else
			pos_cnt <= '0;
	end

	assign byte_end  = scl_fall && bit_cnt == 3'd7;
	assign addr_byte = sbuf[7:0];
	assign addr_ok   = (addr_byte[7:1] == own_addr_i ||
		addr_byte[7:1] == i2c_bridge_pkg::GENERAL_CALL) &&
		(addr_byte[0] ? !tx_empty_i : !rx_full_i);
	// released line pulled low by someone else
	assign rd_err    = state == i2c_bridge_pkg::DRD && sample && !sda_oe_o && !sda;

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_comb begin
		state_n = state;
		case (state)
			i2c_bridge_pkg::IDLE:
				if (start_seen && scl_fall)
					state_n = i2c_bridge_pkg::ADDR;
			i2c_bridge_pkg::ADDR:
				if (byte_end)
					state_n = i2c_bridge_pkg::AACKO;
			i2c_bridge_pkg::DWR:
				if (byte_end)
					state_n = i2c_bridge_pkg::ACKO;
			i2c_bridge_pkg::DRD:
				if (rd_err)
					state_n = i2c_bridge_pkg::IDLE;
				else if (byte_end)
					state_n = i2c_bridge_pkg::ACKI;
			i2c_bridge_pkg::ACKO:
				if (scl_fall)
					state_n = ack_q ? i2c_bridge_pkg::DWR : i2c_bridge_pkg::IDLE;
			i2c_bridge_pkg::AACKO:
				if (scl_fall && !ack_q)
					state_n = i2c_bridge_pkg::IDLE;
				else if (scl_fall)
					state_n = rw ? i2c_bridge_pkg::DRD : i2c_bridge_pkg::DWR;
			i2c_bridge_pkg::ACKI:
				// master nack, or no word left for the next byte
				if (scl_fall && (acki || (byte_cnt == 2'd0 && tx_empty_i)))
					state_n = i2c_bridge_pkg::IDLE;
				else if (scl_fall)
					state_n = i2c_bridge_pkg::DRD;
			default:
				state_n = i2c_bridge_pkg::IDLE;
		endcase
		if (start || stop)
			state_n = i2c_bridge_pkg::IDLE;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= i2c_bridge_pkg::IDLE;
		else
			state <= state_n;
	end

	always_ff @(posedge clk) begin
		if (rst)
			start_seen <= 1'b0;
		else if (start)
			start_seen <= 1'b1;
		else if (scl_fall)
			start_seen <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst || state == i2c_bridge_pkg::IDLE)
			bit_cnt <= '0;
		else if (scl_fall && (state == i2c_bridge_pkg::ADDR ||
			state == i2c_bridge_pkg::DWR || state == i2c_bridge_pkg::DRD))
			bit_cnt <= bit_cnt + 3'd1;
	end

	// bytes within the current word
	always_ff @(posedge clk) begin
		if (rst || state == i2c_bridge_pkg::IDLE)
			byte_cnt <= '0;
		else if (byte_end && (state == i2c_bridge_pkg::DWR || state == i2c_bridge_pkg::DRD))
			byte_cnt <= byte_cnt + 2'd1;
	end

	// ----------------------------------------------------------------------
	// acknowledge decisions
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q       <= 1'b0;
			rw          <= 1'b0;
			ev.dev_addr <= '0;
		end else if (state == i2c_bridge_pkg::ADDR && byte_end) begin
			ack_q <= addr_ok;
			rw    <= addr_byte[0];
			if (addr_ok)
				ev.dev_addr <= addr_byte[7:1];
		end else if (state == i2c_bridge_pkg::DWR && byte_end) begin
			// refuse a byte that would complete a word with nowhere to go
			ack_q <= !(byte_cnt == 2'd3 && rx_full_i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			acki <= 1'b1;
		else if (state == i2c_bridge_pkg::ACKI && sample)
			acki <= sda;
	end

	// sda only moves while scl is low
	always_ff @(posedge clk) begin
		if (rst || state_n == i2c_bridge_pkg::IDLE)
			sda_oe_o <= 1'b0;
		else if (neg_dly) begin
			case (state)
				i2c_bridge_pkg::AACKO,
				i2c_bridge_pkg::ACKO: sda_oe_o <= ack_q;
				i2c_bridge_pkg::DWR:  sda_oe_o <= 1'b0;
				i2c_bridge_pkg::DRD:  sda_oe_o <= !sbuf[31];
				default:              sda_oe_o <= sda_oe_o;
			endcase
		end else if (state == i2c_bridge_pkg::ACKI &&
			neg_cnt == 4'(i2c_bridge_pkg::RD_DLY))
			sda_oe_o <= 1'b0;
	end

	// ----------------------------------------------------------------------
	// shift buffer and fifo strobes
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (tx_pop_o)
			sbuf <= tx_word_i;
		else if (sample && (state == i2c_bridge_pkg::ADDR || state == i2c_bridge_pkg::DWR))
			sbuf <= {sbuf[30:0], sda};
		else if (sample && state == i2c_bridge_pkg::DRD)
			sbuf <= {sbuf[30:0], 1'b0};
	end

	assign rx_word_o = sbuf;

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_pop_o  <= 1'b0;
			rx_push_o <= 1'b0;
		end else begin
			tx_pop_o  <= (state == i2c_bridge_pkg::ADDR && byte_end && addr_ok && addr_byte[0]) ||
				(state == i2c_bridge_pkg::ACKI && state_n == i2c_bridge_pkg::DRD &&
				byte_cnt == 2'd0);
			rx_push_o <= state == i2c_bridge_pkg::DWR && byte_end && byte_cnt == 2'd3 &&
				!rx_full_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ev.wdone <= 1'b0;
			ev.rdone <= 1'b0;
			ev.rerr  <= 1'b0;
		end else begin
			ev.wdone <= state == i2c_bridge_pkg::DWR && (start || stop);
			ev.rdone <= state == i2c_bridge_pkg::ACKI && scl_fall && acki;
			ev.rerr  <= rd_err;
		end
	end

	assert property (@(posedge clk) disable iff (rst) rx_push_o |-> !rx_full_i)
		else $error("receive FIFO pushed while full");

	assert property (@(posedge clk) disable iff (rst) tx_pop_o |-> !tx_empty_i)
		else $error("transmit FIFO popped while empty");

endmodule

// ==== word_fifo.sv ====
module word_fifo (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        push_i,
	input  logic                        pop_i,
	input  i2c_bridge_pkg::word_t       data_i,
	output i2c_bridge_pkg::word_t       data_o,
	output logic                        empty_o,
	output logic                        full_o,
	output i2c_bridge_pkg::fifo_level_t level_o
);

	i2c_bridge_pkg::word_t mem [i2c_bridge_pkg::FIFO_DEPTH];
	logic [$clog2(i2c_bridge_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(i2c_bridge_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign empty_o = level_o == '0;
	assign full_o  = level_o == i2c_bridge_pkg::fifo_level_t'(i2c_bridge_pkg::FIFO_DEPTH);

	// head word visible without a pop
	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop keep the count
			case ({do_push, do_pop})
				2'b10:   level_o <= level_o + 1'b1;
				2'b01:   level_o <= level_o - 1'b1;
				default: level_o <= level_o;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(push_i && full_o) && !(pop_i && empty_o))
		else $error("FIFO overflow or underflow");

endmodule

// ==== i2c_axil_regs.sv ====
module i2c_axil_regs (
	input  logic                       clk,
	input  logic                       rst,
	input  i2c_bridge_pkg::axil_addr_t awaddr_i,
	input  logic                       awvalid_i,
	output logic                       awready_o,
	input  i2c_bridge_pkg::word_t      wdata_i,
	input  logic [3:0]                 wstrb_i,
	input  logic                       wvalid_i,
	output logic                       wready_o,
	output i2c_bridge_pkg::axil_resp_t bresp_o,
	output logic                       bvalid_o,
	input  logic                       bready_i,
	input  i2c_bridge_pkg::axil_addr_t araddr_i,
	input  logic                       arvalid_i,
	output logic                       arready_o,
	output i2c_bridge_pkg::word_t      rdata_o,
	output i2c_bridge_pkg::axil_resp_t rresp_o,
	output logic                       rvalid_o,
	input  logic                       rready_i,
	i2c_event_if.regs                  ev,
	input  i2c_bridge_pkg::word_t      rx_word_i,
	input  logic                       rx_empty_i,
	input  logic                       rx_full_i,
	input  logic                       tx_empty_i,
	input  logic                       tx_full_i,
	output logic                       rx_pop_o,
	output logic                       tx_push_o,
	output i2c_bridge_pkg::word_t      tx_word_o,
	output i2c_bridge_pkg::dev_addr_t  own_addr_o
);

	logic                       wr_hs;
	logic                       rd_hs;
	logic [2:0]                 sticky;
	logic [2:0]                 sticky_clr;
	i2c_bridge_pkg::word_t      status;
	i2c_bridge_pkg::word_t      rd_word;
	i2c_bridge_pkg::axil_resp_t rd_resp;

	// ----------------------------------------------------------------------
	// write channel
	// ----------------------------------------------------------------------
	assign wr_hs     = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = wr_hs;
	assign wready_o  = wr_hs;
	assign tx_push_o = wr_hs && awaddr_i == i2c_bridge_pkg::REG_TXDATA && !tx_full_i;
	assign tx_word_o = wdata_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid_o   <= 1'b0;
			bresp_o    <= i2c_bridge_pkg::RESP_OKAY;
			own_addr_o <= '0;
		end else if (wr_hs) begin
			bvalid_o <= 1'b1;
			bresp_o  <= i2c_bridge_pkg::RESP_OKAY;
			case (awaddr_i)
				i2c_bridge_pkg::REG_CTRL:
					if (wstrb_i[0])
						own_addr_o <= wdata_i[6:0];
				i2c_bridge_pkg::REG_STATUS,
				i2c_bridge_pkg::REG_RXDATA: ;
				i2c_bridge_pkg::REG_TXDATA:
					if (tx_full_i)
						bresp_o <= i2c_bridge_pkg::RESP_SLVERR;
				default:
					bresp_o <= i2c_bridge_pkg::RESP_SLVERR;
			endcase
		end else if (bready_i) begin
			bvalid_o <= 1'b0;
		end
	end

	// event bits, write one to clear; a new event wins over the clear
	assign sticky_clr = (wr_hs && awaddr_i == i2c_bridge_pkg::REG_STATUS && wstrb_i[0]) ?
		wdata_i[i2c_bridge_pkg::ST_RERR:i2c_bridge_pkg::ST_WDONE] : 3'b000;

	always_ff @(posedge clk) begin
		if (rst)
			sticky <= '0;
		else
			sticky <= (sticky & ~sticky_clr) | {ev.rerr, ev.rdone, ev.wdone};
	end

	always_comb begin
		status = '0;
		status[i2c_bridge_pkg::ST_RX_EMPTY] = rx_empty_i;
		status[i2c_bridge_pkg::ST_RX_FULL]  = rx_full_i;
		status[i2c_bridge_pkg::ST_TX_EMPTY] = tx_empty_i;
		status[i2c_bridge_pkg::ST_TX_FULL]  = tx_full_i;
		status[i2c_bridge_pkg::ST_RERR:i2c_bridge_pkg::ST_WDONE] = sticky;
		// last acknowledged device address
		status[14:8] = ev.dev_addr;
	end

	// ----------------------------------------------------------------------
	// read channel
	// ----------------------------------------------------------------------
	assign arready_o = !rvalid_o;
	assign rd_hs     = arvalid_i && arready_o;
	assign rx_pop_o  = rd_hs && araddr_i == i2c_bridge_pkg::REG_RXDATA && !rx_empty_i;

	always_comb begin
		rd_word = '0;
		rd_resp = i2c_bridge_pkg::RESP_OKAY;
		case (araddr_i)
			i2c_bridge_pkg::REG_CTRL:   rd_word = i2c_bridge_pkg::word_t'(own_addr_o);
			i2c_bridge_pkg::REG_STATUS: rd_word = status;
			i2c_bridge_pkg::REG_RXDATA:
				if (rx_empty_i)
					rd_resp = i2c_bridge_pkg::RESP_SLVERR;
				else
					rd_word = rx_word_i;
			i2c_bridge_pkg::REG_TXDATA: rd_word = '0;
			default:                    rd_resp = i2c_bridge_pkg::RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_o <= 1'b0;
			rresp_o  <= i2c_bridge_pkg::RESP_OKAY;
		end else if (rd_hs) begin
			rvalid_o <= 1'b1;
			rresp_o  <= rd_resp;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs)
			rdata_o <= rd_word;
	end

	assert property (@(posedge clk) disable iff (rst)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
		else $error("read data dropped or changed before rready");

endmodule

// ==== i2c_bridge_top.sv ====
module i2c_bridge_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       scl_i,
	input  logic                       sda_i,
	output logic                       sda_oe_o,
	input  i2c_bridge_pkg::axil_addr_t awaddr_i,
	input  logic                       awvalid_i,
	output logic                       awready_o,
	input  i2c_bridge_pkg::word_t      wdata_i,
	input  logic [3:0]                 wstrb_i,
	input  logic                       wvalid_i,
	output logic                       wready_o,
	output i2c_bridge_pkg::axil_resp_t bresp_o,
	output logic                       bvalid_o,
	input  logic                       bready_i,
	input  i2c_bridge_pkg::axil_addr_t araddr_i,
	input  logic                       arvalid_i,
	output logic                       arready_o,
	output i2c_bridge_pkg::word_t      rdata_o,
	output i2c_bridge_pkg::axil_resp_t rresp_o,
	output logic                       rvalid_o,
	input  logic                       rready_i
);

	logic scl;
	logic sda;
	logic scl_rise;
	logic scl_fall;
	logic start;
	logic stop;
	logic rx_push;
	logic rx_pop;
	logic rx_empty;
	logic rx_full;
	logic tx_push;
	logic tx_pop;
	logic tx_empty;
	logic tx_full;
	i2c_bridge_pkg::word_t     rx_wr_word;
	i2c_bridge_pkg::word_t     rx_rd_word;
	i2c_bridge_pkg::word_t     tx_wr_word;
	i2c_bridge_pkg::word_t     tx_rd_word;
	i2c_bridge_pkg::dev_addr_t own_addr;

	i2c_event_if ev ();

	i2c_pin_filter u_filter (
		.clk        (clk),
		.rst        (rst),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.scl_o      (scl),
		.sda_o      (sda),
		.scl_rise_o (scl_rise),
		.scl_fall_o (scl_fall),
		.start_o    (start),
		.stop_o     (stop)
	);

	i2c_target_phy u_phy (
		.clk        (clk),
		.rst        (rst),
		.scl        (scl),
		.sda        (sda),
		.scl_rise   (scl_rise),
		.scl_fall   (scl_fall),
		.start      (start),
		.stop       (stop),
		.own_addr_i (own_addr),
		.rx_full_i  (rx_full),
		.tx_empty_i (tx_empty),
		.tx_word_i  (tx_rd_word),
		.rx_push_o  (rx_push),
		.rx_word_o  (rx_wr_word),
		.tx_pop_o   (tx_pop),
		.sda_oe_o   (sda_oe_o),
		.ev         (ev)
	);

	// bus to host
	word_fifo u_rx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (rx_push),
		.pop_i   (rx_pop),
		.data_i  (rx_wr_word),
		.data_o  (rx_rd_word),
		.empty_o (rx_empty),
		.full_o  (rx_full),
		.level_o ()
	);

	// host to bus
	word_fifo u_tx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (tx_push),
		.pop_i   (tx_pop),
		.data_i  (tx_wr_word),
		.data_o  (tx_rd_word),
		.empty_o (tx_empty),
		.full_o  (tx_full),
		.level_o ()
	);

	// axi ports share their names with the top level
	i2c_axil_regs u_regs (
		.*,
		.ev         (ev),
		.rx_word_i  (rx_rd_word),
		.rx_empty_i (rx_empty),
		.rx_full_i  (rx_full),
		.tx_empty_i (tx_empty),
		.tx_full_i  (tx_full),
		.rx_pop_o   (rx_pop),
		.tx_push_o  (tx_push),
		.tx_word_o  (tx_wr_word),
		.own_addr_o (own_addr)
	);

endmodule

// ==== tb_i2c_bridge.sv ====
module tb_i2c_bridge;

	localparam int HALF_BIT    = 40;
	localparam int AXI_TIMEOUT = 50;
	localparam int POLL_LIMIT  = 20;
	localparam i2c_bridge_pkg::dev_addr_t OWN_ADDR = 7'h52;

	logic                       clk;
	logic                       rst;
	logic                       scl_m;
	logic                       sda_m;
	logic                       sda_line;
	logic                       sda_oe;
	i2c_bridge_pkg::axil_addr_t awaddr;
	logic                       awvalid;
	logic                       awready;
	i2c_bridge_pkg::word_t      wdata;
	logic [3:0]                 wstrb;
	logic                       wvalid;
	logic                       wready;
	i2c_bridge_pkg::axil_resp_t bresp;
	logic                       bvalid;
	logic                       bready;
	i2c_bridge_pkg::axil_addr_t araddr;
	logic                       arvalid;
	logic                       arready;
	i2c_bridge_pkg::word_t      rdata;
	i2c_bridge_pkg::axil_resp_t rresp;
	logic                       rvalid;
	logic                       rready;
	int                         seed;
	string                      test_name;

	// open-drain line where the target pulls low through sda_oe
	assign sda_line = sda_m & ~sda_oe;

	i2c_bridge_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.scl_i     (scl_m),
		.sda_i     (sda_line),
		.sda_oe_o  (sda_oe),
		.awaddr_i  (awaddr),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.bresp_o   (bresp),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.araddr_i  (araddr),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rvalid_o  (rvalid),
		.rready_i  (rready)
	);

	always #50 clk = ~clk;

	// ----------------------------------------------------------------------
	// failure reporting and checks
	// ----------------------------------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input i2c_bridge_pkg::word_t exp,
		input i2c_bridge_pkg::word_t act);
		if (act !== exp)
			fail_run($sformatf("** Error %s %s: expected %h, actual %h", test_name, name, exp, act));
	endtask

	task automatic check_resp(input string name, input i2c_bridge_pkg::axil_resp_t exp,
		input i2c_bridge_pkg::axil_resp_t act);
		if (act !== exp)
			fail_run($sformatf("** Error %s %s: expected %0d, actual %0d", test_name, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("** Error %s %s: expected %b, actual %b", test_name, name, exp, act));
	endtask

	task automatic hold(input int n);
		repeat (n) @(posedge clk);
	endtask

	// ----------------------------------------------------------------------
	// axi4-lite host
	// ----------------------------------------------------------------------
	task automatic axil_write(input i2c_bridge_pkg::axil_addr_t addr,
		input i2c_bridge_pkg::word_t data, output i2c_bridge_pkg::axil_resp_t resp);
		int n;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= 4'hF;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > AXI_TIMEOUT)
				fail_run("write address and data were never accepted");
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > AXI_TIMEOUT)
				fail_run("write response never arrived");
		end while (!bvalid);
		bready <= 1'b0;
		resp = bresp;
	endtask

	task automatic axil_read(input i2c_bridge_pkg::axil_addr_t addr,
		output i2c_bridge_pkg::word_t data, output i2c_bridge_pkg::axil_resp_t resp);
		int n;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > AXI_TIMEOUT)
				fail_run("read address was never accepted");
		end while (!arready);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > AXI_TIMEOUT)
				fail_run("read data never arrived");
		end while (!rvalid);
		rready <= 1'b0;
		data = rdata;
		resp = rresp;
	endtask

	task automatic read_status(output i2c_bridge_pkg::word_t st);
		i2c_bridge_pkg::axil_resp_t resp;
		axil_read(i2c_bridge_pkg::REG_STATUS, st, resp);
		check_resp("status read", i2c_bridge_pkg::RESP_OKAY, resp);
	endtask

	task automatic wait_status(input int pos, input string what);
		i2c_bridge_pkg::word_t st;
		int n;
		n = 0;
		do begin
			if (n == POLL_LIMIT)
				fail_run({what, " never showed up in the status register"});
			read_status(st);
			n++;
		end while (!st[pos]);
	endtask

	// ----------------------------------------------------------------------
	// i2c master
	// ----------------------------------------------------------------------
	// sda moves mid-way through scl low and is sampled mid-way through scl high
	task automatic clock_bit(input logic b, output logic r);
		@(posedge clk);
		scl_m <= 1'b0;
		hold(HALF_BIT / 2);
		sda_m <= b;
		hold(HALF_BIT / 2);
		scl_m <= 1'b1;
		hold(HALF_BIT / 2);
		r = sda_line;
		hold(HALF_BIT / 2);
	endtask

	task automatic i2c_start;
		@(posedge clk);
		sda_m <= 1'b0;
		hold(HALF_BIT);
	endtask

	task automatic i2c_stop;
		@(posedge clk);
		scl_m <= 1'b0;
		hold(HALF_BIT / 2);
		sda_m <= 1'b0;
		hold(HALF_BIT / 2);
		scl_m <= 1'b1;
		hold(HALF_BIT / 2);
		sda_m <= 1'b1;
		hold(HALF_BIT);
	endtask

	task automatic i2c_write_byte(input i2c_bridge_pkg::byte_t b, output logic ack);
		logic r;
		int i;
		for (i = 7; i >= 0; i--)
			clock_bit(b[i], r);
		clock_bit(1'b1, r);
		ack = !r;
	endtask

	task automatic i2c_read_byte(input logic nack, output i2c_bridge_pkg::byte_t b);
		logic r;
		int i;
		for (i = 7; i >= 0; i--) begin
			clock_bit(1'b1, r);
			b[i] = r;
		end
		clock_bit(nack, r);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_registers;
		i2c_bridge_pkg::word_t      data;
		i2c_bridge_pkg::axil_resp_t resp;
		test_name = "registers";
		read_status(data);
		check_bit("rx empty after reset", 1'b1, data[i2c_bridge_pkg::ST_RX_EMPTY]);
		check_bit("tx empty after reset", 1'b1, data[i2c_bridge_pkg::ST_TX_EMPTY]);
		axil_read(i2c_bridge_pkg::REG_CTRL, data, resp);
		check_word("ctrl after reset", '0, data);
		axil_write(i2c_bridge_pkg::REG_CTRL, i2c_bridge_pkg::word_t'(OWN_ADDR), resp);
		check_resp("ctrl write", i2c_bridge_pkg::RESP_OKAY, resp);
		axil_read(i2c_bridge_pkg::REG_CTRL, data, resp);
		check_resp("ctrl read", i2c_bridge_pkg::RESP_OKAY, resp);
		check_word("ctrl readback", i2c_bridge_pkg::word_t'(OWN_ADDR), data);
		// 0x6 is not decoded
		axil_read(4'h6, data, resp);
		check_resp("unmapped read", i2c_bridge_pkg::RESP_SLVERR, resp);
		axil_write(4'h6, 32'h1234_5678, resp);
		check_resp("unmapped write", i2c_bridge_pkg::RESP_SLVERR, resp);
		axil_read(i2c_bridge_pkg::REG_RXDATA, data, resp);
		check_resp("rxdata read while empty", i2c_bridge_pkg::RESP_SLVERR, resp);
	endtask

	task automatic test_master_write;
		i2c_bridge_pkg::byte_t      bytes [8];
		i2c_bridge_pkg::word_t      data;
		i2c_bridge_pkg::axil_resp_t resp;
		logic                       ack;
		int                         i;
		test_name = "master_write";
		for (i = 0; i < 8; i++)
			bytes[i] = i2c_bridge_pkg::byte_t'($random(seed));
		i2c_start();
		i2c_write_byte({OWN_ADDR, 1'b0}, ack);
		check_bit("address ack", 1'b1, ack);
		for (i = 0; i < 8; i++) begin
			i2c_write_byte(bytes[i], ack);
			check_bit("data ack", 1'b1, ack);
		end
		i2c_stop();
		wait_status(i2c_bridge_pkg::ST_WDONE, "write done");
		read_status(data);
		check_word("last device address", i2c_bridge_pkg::word_t'(OWN_ADDR),
			i2c_bridge_pkg::word_t'(data[14:8]));
		// first byte on the bus lands in the top byte
		for (i = 0; i < 2; i++) begin
			axil_read(i2c_bridge_pkg::REG_RXDATA, data, resp);
			check_resp("rxdata read", i2c_bridge_pkg::RESP_OKAY, resp);
			check_word("rx word", {bytes[4*i], bytes[4*i+1], bytes[4*i+2], bytes[4*i+3]}, data);
		end
		read_status(data);
		check_bit("rx empty after reads", 1'b1, data[i2c_bridge_pkg::ST_RX_EMPTY]);
		axil_write(i2c_bridge_pkg::REG_STATUS,
			i2c_bridge_pkg::word_t'(1) << i2c_bridge_pkg::ST_WDONE, resp);
		read_status(data);
		check_bit("wdone cleared", 1'b0, data[i2c_bridge_pkg::ST_WDONE]);
	endtask

	task automatic test_master_read;
		i2c_bridge_pkg::word_t      words [2];
		i2c_bridge_pkg::word_t      got;
		i2c_bridge_pkg::word_t      data;
		i2c_bridge_pkg::byte_t      rx;
		i2c_bridge_pkg::axil_resp_t resp;
		logic                       ack;
		int                         i;
		test_name = "master_read";
		got = '0;
		for (i = 0; i < 2; i++) begin
			words[i] = i2c_bridge_pkg::word_t'($random(seed));
			axil_write(i2c_bridge_pkg::REG_TXDATA, words[i], resp);
			check_resp("txdata write", i2c_bridge_pkg::RESP_OKAY, resp);
		end
		i2c_start();
		i2c_write_byte({OWN_ADDR, 1'b1}, ack);
		check_bit("address ack", 1'b1, ack);
		for (i = 0; i < 8; i++) begin
			i2c_read_byte(i == 7, rx);
			got = {got[23:0], rx};
			if (i % 4 == 3)
				check_word("tx word", words[i / 4], got);
		end
		i2c_stop();
		wait_status(i2c_bridge_pkg::ST_RDONE, "read done");
		read_status(data);
		check_bit("tx empty after read", 1'b1, data[i2c_bridge_pkg::ST_TX_EMPTY]);
	endtask

	task automatic test_refusals;
		i2c_bridge_pkg::word_t      words [4];
		i2c_bridge_pkg::word_t      data;
		i2c_bridge_pkg::axil_resp_t resp;
		logic                       ack;
		int                         i;
		test_name = "refusals";
		i2c_start();
		i2c_write_byte({7'h13, 1'b0}, ack);
		check_bit("wrong address", 1'b0, ack);
		i2c_stop();
		i2c_start();
		i2c_write_byte({i2c_bridge_pkg::GENERAL_CALL, 1'b1}, ack);
		check_bit("general call read, tx empty", 1'b0, ack);
		i2c_stop();
		// fill the receive fifo with four words
		for (i = 0; i < 4; i++)
			words[i] = i2c_bridge_pkg::word_t'($random(seed));
		i2c_start();
		i2c_write_byte({OWN_ADDR, 1'b0}, ack);
		check_bit("fill address ack", 1'b1, ack);
		for (i = 0; i < 16; i++) begin
			i2c_write_byte(i2c_bridge_pkg::byte_t'(words[i / 4] >> (24 - 8 * (i % 4))), ack);
			check_bit("fill data ack", 1'b1, ack);
		end
		i2c_stop();
		read_status(data);
		check_bit("rx full", 1'b1, data[i2c_bridge_pkg::ST_RX_FULL]);
		i2c_start();
		i2c_write_byte({OWN_ADDR, 1'b0}, ack);
		check_bit("write with rx full", 1'b0, ack);
		i2c_stop();
		for (i = 0; i < 4; i++) begin
			axil_read(i2c_bridge_pkg::REG_RXDATA, data, resp);
			check_resp("drain read", i2c_bridge_pkg::RESP_OKAY, resp);
			check_word("drained word", words[i], data);
		end
	endtask

	task automatic test_read_error;
		i2c_bridge_pkg::axil_resp_t resp;
		logic                       ack;
		logic                       r;
		test_name = "read_error";
		// top bit is one and the next bit is zero
		axil_write(i2c_bridge_pkg::REG_TXDATA, 32'hA5C3_0F96, resp);
		check_resp("txdata write", i2c_bridge_pkg::RESP_OKAY, resp);
		i2c_start();
		i2c_write_byte({OWN_ADDR, 1'b1}, ack);
		check_bit("address ack", 1'b1, ack);
		clock_bit(1'b0, r);
		// target would pull low here if still sending
		clock_bit(1'b1, r);
		check_bit("sda released", 1'b1, r);
		check_bit("sda_oe after error", 1'b0, sda_oe);
		i2c_stop();
		wait_status(i2c_bridge_pkg::ST_RERR, "read error");
	endtask

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		scl_m     = 1'b1;
		sda_m     = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		seed      = 57184;
		test_name = "reset";
		hold(8);
		rst <= 1'b0;
		hold(2);
		test_registers();
		test_master_write();
		test_master_read();
		test_refusals();
		test_read_error();
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
i2c_bridge_pkg.sv
i2c_event_if.sv
i2c_pin_filter.sv
i2c_target_phy.sv
word_fifo.sv
i2c_axil_regs.sv
i2c_bridge_top.sv
tb_i2c_bridge.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_i2c_bridge
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
